// File: compile.f
verilog/glb_pkg.sv
verilog/glb_bank.sv
verilog/host_bank_interface.sv
verilog/global_buffer.sv
bench/global_buffer_sva.sv
bench/global_buffer_tb.sv

// File: Bender.yml
package:
  name: global_buffer

sources:
  # Package first, then the banks, the interface and the top level.
  - files:
      - verilog/glb_pkg.sv
      - verilog/glb_bank.sv
      - verilog/host_bank_interface.sv
      - verilog/global_buffer.sv

  # Bench sources, bound assertions ahead of the testbench top.
  - target: simulation
    files:
      - bench/global_buffer_sva.sv
      - bench/global_buffer_tb.sv

// File: bench/global_buffer_tb.sv
// Global buffer testbench
module global_buffer_tb;
    import glb_pkg::*;

    // Geometry taken from the package defaults.
    localparam int ADDR_W = $clog2(GLB_NUM_BANKS) + GLB_BANK_ADDR_WIDTH;
    localparam int DATA_W = GLB_BANK_DATA_WIDTH;

    // Op codes.
    // Bit 0 is a write, bit 1 a read.
    localparam logic [1:0] OP_IDLE = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_RD   = 2'd2;
    localparam logic [1:0] OP_BOTH = 2'd3;

    // One row per cycle.
    typedef struct packed {
        logic [1:0]        op;
        logic              rnd;
        logic [ADDR_W-1:0] wr_addr;
        logic [DATA_W-1:0] wr_data;
        logic [ADDR_W-1:0] rd_addr;
        logic              use_model;
        logic [DATA_W-1:0] exp_data;
    } row_t;

    localparam int NUM_ROWS = 35;

    // Address is bank index in bits 7:6 and word offset below.
    // Fields are op, rnd, wr_addr, wr_data, rd_addr, use_model, exp_data.
    localparam row_t TEST_TABLE [NUM_ROWS] = '{
        // Quiet start after reset.
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        // Write then read with a gap.
        '{OP_WR,   1'b0, 8'h03, 64'h0123_4567_89ab_cdef, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b0, 8'h04, 64'hfedc_ba98_7654_3210, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h03, 1'b0, 64'h0123_4567_89ab_cdef},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h04, 1'b0, 64'hfedc_ba98_7654_3210},
        // Same offset in every bank.
        '{OP_WR,   1'b0, 8'h10, 64'h0000_0000_0000_b0b0, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b0, 8'h50, 64'h1111_1111_1111_b1b1, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b0, 8'h90, 64'h2222_2222_2222_b2b2, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b0, 8'hd0, 64'h3333_3333_3333_b3b3, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h10, 1'b0, 64'h0000_0000_0000_b0b0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h50, 1'b0, 64'h1111_1111_1111_b1b1},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h90, 1'b0, 64'h2222_2222_2222_b2b2},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'hd0, 1'b0, 64'h3333_3333_3333_b3b3},
        // Random words, then back-to-back reads on alternating banks.
        '{OP_WR,   1'b1, 8'h21, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b1, 8'h61, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h21, 1'b1, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h61, 1'b1, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h21, 1'b1, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h61, 1'b1, 64'h0},
        // Read right behind a write to the same word.
        '{OP_WR,   1'b0, 8'h07, 64'haaaa_aaaa_aaaa_aaaa, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_WR,   1'b0, 8'h07, 64'h5555_5555_5555_5555, 8'h00, 1'b0, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h07, 1'b1, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h07, 1'b1, 64'h0},
        // Read and write to different banks in one cycle.
        '{OP_BOTH, 1'b0, 8'he2, 64'hc0de_c0de_c0de_c0de, 8'h50, 1'b0, 64'h1111_1111_1111_b1b1},
        '{OP_BOTH, 1'b1, 8'h33, 64'h0, 8'h90, 1'b0, 64'h2222_2222_2222_b2b2},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'he2, 1'b0, 64'hc0de_c0de_c0de_c0de},
        '{OP_RD,   1'b0, 8'h00, 64'h0, 8'h33, 1'b1, 64'h0},
        '{OP_IDLE, 1'b0, 8'h00, 64'h0, 8'h00, 1'b0, 64'h0}
    };

    // Run limit covering the table, reset and margin.
    localparam int TIMEOUT = (NUM_ROWS + 4 + 20) * 10;

    logic              clk;
    logic              reset;
    logic              soc_port_wr_en;
    logic [ADDR_W-1:0] soc_port_wr_addr;
    logic [DATA_W-1:0] soc_port_wr_data;
    logic              soc_port_rd_en;
    logic [ADDR_W-1:0] soc_port_rd_addr;
    logic [DATA_W-1:0] soc_port_rd_data;
    logic              soc_port_rd_data_valid;

    integer seed = 32'h3c98_fa9f;

    // Reference memory and expected read returns.
    logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]];
    logic              exp_valid_q [$];
    logic [DATA_W-1:0] exp_data_q [$];

    global_buffer #(
        .NUM_BANKS       (GLB_NUM_BANKS),
        .BANK_DATA_WIDTH (GLB_BANK_DATA_WIDTH),
        .BANK_ADDR_WIDTH (GLB_BANK_ADDR_WIDTH)
    ) u_dut (
        .clk                    (clk),
        .reset                  (reset),
        .soc_port_wr_en         (soc_port_wr_en),
        .soc_port_wr_addr       (soc_port_wr_addr),
        .soc_port_wr_data       (soc_port_wr_data),
        .soc_port_rd_en         (soc_port_rd_en),
        .soc_port_rd_addr       (soc_port_rd_addr),
        .soc_port_rd_data       (soc_port_rd_data),
        .soc_port_rd_data_valid (soc_port_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Compare and stop at the first mismatch.
    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Put one table row on the SoC port.
    task automatic drive_row(input row_t row);
        soc_port_wr_en   = row.op[0];
        soc_port_wr_addr = row.wr_addr;
        if (row.rnd) begin
            soc_port_wr_data = {$random(seed), $random(seed)};
        end else begin
            soc_port_wr_data = row.wr_data;
        end
        soc_port_rd_en   = row.op[1];
        soc_port_rd_addr = row.rd_addr;
    endtask

    // Main sequence.
    initial begin
        row_t              row;
        logic [DATA_W-1:0] exp_data;
        logic [DATA_W-1:0] exp_word;
        logic              exp_valid;
        logic              pend1_en;
        logic              pend2_en;
        logic [ADDR_W-1:0] pend1_addr;
        logic [ADDR_W-1:0] pend2_addr;
        logic [DATA_W-1:0] pend1_data;
        logic [DATA_W-1:0] pend2_data;

        reset            = 1'b1;
        soc_port_wr_en   = 1'b0;
        soc_port_wr_addr = '0;
        soc_port_wr_data = '0;
        soc_port_rd_en   = 1'b0;
        soc_port_rd_addr = '0;
        pend1_en         = 1'b0;
        pend2_en         = 1'b0;
        pend1_addr       = '0;
        pend2_addr       = '0;
        pend1_data       = '0;
        pend2_data       = '0;

        // Nothing returns in the first two checks.
        exp_valid_q.push_back(1'b0);
        exp_data_q.push_back('0);
        exp_valid_q.push_back(1'b0);
        exp_data_q.push_back('0);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Two extra idle rows drain the read pipeline.
        for (int i = 0; i < NUM_ROWS + 2; i++) begin
            @(posedge clk);
            #1;
            // Return of the row issued two cycles back.
            exp_valid = exp_valid_q.pop_front();
            exp_word  = exp_data_q.pop_front();
            check_value("soc_port_rd_data_valid", soc_port_rd_data_valid, exp_valid);
            if (exp_valid) begin
                check_value("soc_port_rd_data", soc_port_rd_data, exp_word);
            end

            // Write from two rows back has landed.
            if (pend2_en) begin
                model_mem[pend2_addr] = pend2_data;
            end

            row = (i < NUM_ROWS) ? TEST_TABLE[i] : '0;
            drive_row(row);

            // Expected read seen at issue time.
            if (row.op[1]) begin
                if (row.use_model) begin
                    if (!model_mem.exists(row.rd_addr)) begin
                        $display("Row %0d reads address 0x%h that was never written",
                                 i, row.rd_addr);
                        $display("Simulation failed");
                        $fatal(1, "bad test table");
                    end
                    exp_data = model_mem[row.rd_addr];
                end else begin
                    exp_data = row.exp_data;
                end
                exp_valid_q.push_back(1'b1);
                exp_data_q.push_back(exp_data);
            end else begin
                exp_valid_q.push_back(1'b0);
                exp_data_q.push_back('0);
            end

            // Writes wait one more row before the model sees them.
            pend2_en   = pend1_en;
            pend2_addr = pend1_addr;
            pend2_data = pend1_data;
            pend1_en   = soc_port_wr_en;
            pend1_addr = soc_port_wr_addr;
            pend1_data = soc_port_wr_data;
        end

        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog.
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired, the run timed out before the test table finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

// File: bench/global_buffer_sva.sv
// Host interface decode and timing assertions
module global_buffer_sva #(
    parameter int NUM_BANKS = glb_pkg::GLB_NUM_BANKS
) (
    input logic clk,
    input logic reset,
    input logic soc_port_wr_en,
    input logic soc_port_rd_en,
    input logic soc_port_rd_data_valid,
    input logic host_wr_en [NUM_BANKS-1:0],
    input logic host_rd_en [NUM_BANKS-1:0]
);
    import glb_pkg::*;

    // Bank enables flattened into vectors.
    logic [NUM_BANKS-1:0] wr_en_vec;
    logic [NUM_BANKS-1:0] rd_en_vec;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            wr_en_vec[i] = host_wr_en[i];
            rd_en_vec[i] = host_rd_en[i];
        end
    end

    // At most one bank written per cycle.
    wr_en_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(wr_en_vec))
        else $error("host_wr_en has more than one bank enabled");

    // At most one bank read per cycle.
    rd_en_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rd_en_vec))
        else $error("host_rd_en has more than one bank enabled");

    // Fixed read latency at the SoC port.
    rd_return_latency: assert property (@(posedge clk) disable iff (reset)
        soc_port_rd_en |-> ##GLB_HOST_RD_LATENCY soc_port_rd_data_valid)
        else $error("soc_port_rd_data_valid missing after a read request");

    // A write reaches exactly one bank one cycle later.
    wr_reaches_bank: assert property (@(posedge clk) disable iff (reset)
        soc_port_wr_en |=> $onehot(wr_en_vec))
        else $error("write request did not enable exactly one bank");

endmodule

bind host_bank_interface global_buffer_sva #(
    .NUM_BANKS (NUM_BANKS)
) u_global_buffer_sva (
    .clk                    (clk),
    .reset                  (reset),
    .soc_port_wr_en         (soc_port_wr_en),
    .soc_port_rd_en         (soc_port_rd_en),
    .soc_port_rd_data_valid (soc_port_rd_data_valid),
    .host_wr_en             (host_wr_en),
    .host_rd_en             (host_rd_en)
);

// File: verilog/global_buffer.sv
// Banked global buffer top level
module global_buffer #(
    parameter int NUM_BANKS = glb_pkg::GLB_NUM_BANKS,
    parameter int BANK_DATA_WIDTH = glb_pkg::GLB_BANK_DATA_WIDTH,
    parameter int BANK_ADDR_WIDTH = glb_pkg::GLB_BANK_ADDR_WIDTH,
    localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
    localparam int GLB_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       reset,

    // SoC write request.
    input  logic                       soc_port_wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0]  soc_port_wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0] soc_port_wr_data,

    // SoC read request.
    input  logic                       soc_port_rd_en,
    input  logic [GLB_ADDR_WIDTH-1:0]  soc_port_rd_addr,

    // SoC read return, two cycles after the request.
    output logic [BANK_DATA_WIDTH-1:0] soc_port_rd_data,
    output logic                       soc_port_rd_data_valid
);

    // Host to bank write links.
    logic                       host_wr_en   [NUM_BANKS-1:0];
    logic [BANK_DATA_WIDTH-1:0] host_wr_data [NUM_BANKS-1:0];
    logic [BANK_ADDR_WIDTH-1:0] host_wr_addr [NUM_BANKS-1:0];

    // Host to bank read links.
    logic                       host_rd_en   [NUM_BANKS-1:0];
    logic [BANK_ADDR_WIDTH-1:0] host_rd_addr [NUM_BANKS-1:0];

    // Bank read data back to the interface.
    logic [BANK_DATA_WIDTH-1:0] host_rd_data [NUM_BANKS-1:0];

    // Address decode, write pipeline and read return.
    host_bank_interface #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_DATA_WIDTH (BANK_DATA_WIDTH),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) u_host_bank_interface (
        .clk                    (clk),
        .reset                  (reset),
        .soc_port_wr_en         (soc_port_wr_en),
        .soc_port_wr_addr       (soc_port_wr_addr),
        .soc_port_wr_data       (soc_port_wr_data),
        .soc_port_rd_en         (soc_port_rd_en),
        .soc_port_rd_addr       (soc_port_rd_addr),
        .soc_port_rd_data       (soc_port_rd_data),
        .soc_port_rd_data_valid (soc_port_rd_data_valid),
        .host_wr_en             (host_wr_en),
        .host_wr_data           (host_wr_data),
        .host_wr_addr           (host_wr_addr),
        .host_rd_en             (host_rd_en),
        .host_rd_data           (host_rd_data),
        .host_rd_addr           (host_rd_addr)
    );

    // Bank array.
    // One bank per index value, each on its own slice of the links.
    for (genvar i = 0; i < NUM_BANKS; i++) begin : u_bank
        glb_bank #(
            .BANK_DATA_WIDTH (BANK_DATA_WIDTH),
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
        ) u_glb_bank (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (host_wr_en[i]),
            .wr_addr (host_wr_addr[i]),
            .wr_data (host_wr_data[i]),
            .rd_en   (host_rd_en[i]),
            .rd_addr (host_rd_addr[i]),
            .rd_data (host_rd_data[i])
        );
    end

endmodule

// File: verilog/host_bank_interface.sv
// SoC port to bank array interface
module host_bank_interface #(
    parameter int NUM_BANKS = glb_pkg::GLB_NUM_BANKS,
    parameter int BANK_DATA_WIDTH = glb_pkg::GLB_BANK_DATA_WIDTH,
    parameter int BANK_ADDR_WIDTH = glb_pkg::GLB_BANK_ADDR_WIDTH,
    localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
    localparam int GLB_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       reset,

    // SoC write request.
    input  logic                       soc_port_wr_en,
    input  logic [GLB_ADDR_WIDTH-1:0]  soc_port_wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0] soc_port_wr_data,

    // SoC read request and return.
    input  logic                       soc_port_rd_en,
    input  logic [GLB_ADDR_WIDTH-1:0]  soc_port_rd_addr,
    output logic [BANK_DATA_WIDTH-1:0] soc_port_rd_data,
    output logic                       soc_port_rd_data_valid,

    // Per-bank write links.
    output logic                       host_wr_en   [NUM_BANKS-1:0],
    output logic [BANK_DATA_WIDTH-1:0] host_wr_data [NUM_BANKS-1:0],
    output logic [BANK_ADDR_WIDTH-1:0] host_wr_addr [NUM_BANKS-1:0],

    // Per-bank read links.
    output logic                       host_rd_en   [NUM_BANKS-1:0],
    input  logic [BANK_DATA_WIDTH-1:0] host_rd_data [NUM_BANKS-1:0],
    output logic [BANK_ADDR_WIDTH-1:0] host_rd_addr [NUM_BANKS-1:0]
);
    import glb_pkg::*;

    // Last stage of the read tag pipeline.
    localparam int RD_TAG_LAST = GLB_HOST_RD_LATENCY - 1;

    // Write side.
    logic [BANK_SEL_WIDTH-1:0]  wr_bank_sel;
    logic                       wr_en_dec [NUM_BANKS-1:0];
    logic                       wr_en_q   [NUM_BANKS-1:0];
    logic [BANK_ADDR_WIDTH-1:0] wr_addr_q;
    logic [BANK_DATA_WIDTH-1:0] wr_data_q;

    // Read side.
    logic [BANK_SEL_WIDTH-1:0]  rd_bank_sel;
    logic [BANK_SEL_WIDTH-1:0]  rd_sel_pipe [GLB_HOST_RD_LATENCY];
    logic [RD_TAG_LAST:0]       rd_valid_pipe;
    logic [BANK_DATA_WIDTH-1:0] rd_data_q [NUM_BANKS-1:0];

    // Bank index from the upper address bits.
    assign wr_bank_sel = soc_port_wr_addr[BANK_ADDR_WIDTH +: BANK_SEL_WIDTH];
    assign rd_bank_sel = soc_port_rd_addr[BANK_ADDR_WIDTH +: BANK_SEL_WIDTH];

    // One-hot write decode.
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            wr_en_dec[i] = soc_port_wr_en && (wr_bank_sel == BANK_SEL_WIDTH'(i));
        end
    end

    // Write pipeline stage.
    // Enables clear on reset, offset and data load only on a write.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                wr_en_q[i] <= 1'b0;
            end
            wr_addr_q <= '0;
            wr_data_q <= '0;
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                wr_en_q[i] <= wr_en_dec[i];
            end
            if (soc_port_wr_en) begin
                wr_addr_q <= soc_port_wr_addr[BANK_ADDR_WIDTH-1:0];
                wr_data_q <= soc_port_wr_data;
            end
        end
    end

    // Offset and data fan out to all banks.
    // Only the enabled bank stores.
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            host_wr_en[i]   = wr_en_q[i];
            host_wr_addr[i] = wr_addr_q;
            host_wr_data[i] = wr_data_q;
        end
    end

    // Read enables go straight to the banks.
    // The bank register provides the first cycle of latency.
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            host_rd_en[i]   = soc_port_rd_en && (rd_bank_sel == BANK_SEL_WIDTH'(i));
            host_rd_addr[i] = soc_port_rd_addr[BANK_ADDR_WIDTH-1:0];
        end
    end

    // Bank index and valid travel alongside the data.
    // Stage 0 lines up with the bank output, the last with the return register.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < GLB_HOST_RD_LATENCY; s++) begin
                rd_sel_pipe[s] <= '0;
            end
            rd_valid_pipe <= '0;
        end else begin
            rd_sel_pipe[0] <= rd_bank_sel;
            for (int s = 1; s < GLB_HOST_RD_LATENCY; s++) begin
                rd_sel_pipe[s] <= rd_sel_pipe[s-1];
            end
            rd_valid_pipe <= {rd_valid_pipe[RD_TAG_LAST-1:0], soc_port_rd_en};
        end
    end

    // Return register on every bank output.
    // Keeps the wide output mux off the bank read path.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_data_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_data_q[i] <= host_rd_data[i];
            end
        end
    end

    // Select the tagged bank.
    assign soc_port_rd_data       = rd_data_q[rd_sel_pipe[RD_TAG_LAST]];
    assign soc_port_rd_data_valid = rd_valid_pipe[RD_TAG_LAST];

endmodule

// File: verilog/glb_bank.sv
// Global buffer storage bank
module glb_bank #(
    parameter int BANK_DATA_WIDTH = glb_pkg::GLB_BANK_DATA_WIDTH,
    parameter int BANK_ADDR_WIDTH = glb_pkg::GLB_BANK_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       reset,

    // Write port.
    input  logic                       wr_en,
    input  logic [BANK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0] wr_data,

    // Read port.
    input  logic                       rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0] rd_addr,
    output logic [BANK_DATA_WIDTH-1:0] rd_data
);
    import glb_pkg::*;

    // Words per bank.
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    // Word storage.
    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // Read stages.
    // Stage 0 is the read register, any later ones retime it.
    logic [BANK_DATA_WIDTH-1:0] rd_pipe [GLB_BANK_RD_LATENCY];

    // Write on enable.
    // Contents survive reset.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read register.
    // Loads on rd_en, holds otherwise.
    // Nonblocking update gives old data on a same-edge write.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < GLB_BANK_RD_LATENCY; s++) begin
                rd_pipe[s] <= '0;
            end
        end else begin
            if (rd_en) begin
                rd_pipe[0] <= mem[rd_addr];
            end
            for (int s = 1; s < GLB_BANK_RD_LATENCY; s++) begin
                rd_pipe[s] <= rd_pipe[s-1];
            end
        end
    end

    // Last stage drives the port.
    assign rd_data = rd_pipe[GLB_BANK_RD_LATENCY-1];

endmodule

// File: verilog/glb_pkg.sv
// Global buffer geometry constants
package glb_pkg;

    // Default geometry.
    // Banks sit side by side in the global address map.
    // The bank index occupies the upper address bits.

    // Number of banks, a power of two.
    localparam int GLB_NUM_BANKS = 4;

    // Width of one bank word in bits.
    localparam int GLB_BANK_DATA_WIDTH = 64;

    // Word offset inside a bank.
    // Six bits give 64 words per bank.
    localparam int GLB_BANK_ADDR_WIDTH = 6;

    // Pipeline latencies.
    // Counted in clock edges from the sampled request.

    // Bank read enable to valid bank read data.
    // One registered read stage in the bank.
    localparam int GLB_BANK_RD_LATENCY = 1;

    // SoC read request to valid SoC read data.
    // Bank stage plus one return register in the interface.
    localparam int GLB_HOST_RD_LATENCY = 2;

    // Writes land one edge after the request.
    // A read right behind a write to the same word sees old data.
    // Two or more cycles later it sees the new word.

    // No back-pressure anywhere.
    // Every request is taken in the cycle it is presented.

endpackage
